/* bench/mram_test_properties.sv */
`timescale 1ns/1ps

module mram_test_properties
    import mram_test_pkg::*;
#(
    parameter int CYCLE_TPRE  = CYCLE_TPRE_DEF,
    parameter int CYCLE_TREAD = CYCLE_TREAD_DEF,
    parameter int CYCLE_TRONA = CYCLE_TRONA_DEF,
    parameter int FIFO_DEPTH  = FIFO_DEPTH_DEF
) (
    input logic CLK_200,
    input logic Rst_n,
    input logic en_i,
    input logic r_clk_i,
    input logic mux_en_i,
    input logic tx_start_i,
    input logic tx_done_i,
    // packer pop strobe inside the top level
    input logic pop_i
);

    localparam int T_READ = CYCLE_TPRE + CYCLE_TREAD + CYCLE_TRONA;

    // en cycles seen so far in this read
    int   en_run;
    // reads started whose record has not left the fifo
    int   in_flight;
    // a byte is out and waits for tx_done
    logic tx_wait;
    logic en_len_ok;
    int   prop_fail_cnt = 0;

    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            en_run    <= 0;
            in_flight <= 0;
            tx_wait   <= 1'b0;
        end else begin
            en_run    <= en_i ? en_run + 1 : 0;
            in_flight <= in_flight + ((en_i && en_run == 0) ? 1 : 0) - (pop_i ? 1 : 0);
            if (tx_start_i) begin
                tx_wait <= 1'b1;
            end else if (tx_done_i) begin
                tx_wait <= 1'b0;
            end
        end
    end

    // en never runs past a full read and never stops short of one
    assign en_len_ok = en_i ? (en_run < T_READ) : (en_run == 0 || en_run == T_READ);

    ////////////////////
    // read timing

    a_idle_flag: assert property (@(posedge CLK_200) disable iff (!Rst_n)
        mux_en_i == !en_i)
        else begin
            $error("mux_en_o does not mark the idle sequencer");
            prop_fail_cnt++;
        end

    a_en_length: assert property (@(posedge CLK_200) disable iff (!Rst_n) en_len_ok)
        else begin
            $error("en_o high for %0d cycles, expected %0d", en_run, T_READ);
            prop_fail_cnt++;
        end

    // strobe window sits right after precharge
    a_rclk_window: assert property (@(posedge CLK_200) disable iff (!Rst_n)
        r_clk_i == (en_i && en_run >= CYCLE_TPRE && en_run < CYCLE_TPRE + CYCLE_TREAD))
        else begin
            $error("r_clk_o outside its window in read cycle %0d", en_run);
            prop_fail_cnt++;
        end

    ////////////////////
    // uart and credits

    a_tx_handshake: assert property (@(posedge CLK_200) disable iff (!Rst_n)
        tx_start_i |-> !tx_wait)
        else begin
            $error("tx_start_o while the previous byte waits for tx_done_i");
            prop_fail_cnt++;
        end

    a_credit_bound: assert property (@(posedge CLK_200) disable iff (!Rst_n)
        in_flight <= FIFO_DEPTH)
        else begin
            $error("%0d records outstanding, fifo holds %0d", in_flight, FIFO_DEPTH);
            prop_fail_cnt++;
        end

endmodule

bind mram_test_top mram_test_properties #(
    .CYCLE_TPRE  (CYCLE_TPRE),
    .CYCLE_TREAD (CYCLE_TREAD),
    .CYCLE_TRONA (CYCLE_TRONA),
    .FIFO_DEPTH  (FIFO_DEPTH)
) u_props (
    .CLK_200    (CLK_200),
    .Rst_n      (Rst_n),
    .en_i       (en_o),
    .r_clk_i    (r_clk_o),
    .mux_en_i   (mux_en_o),
    .tx_start_i (tx_start_o),
    .tx_done_i  (tx_done_i),
    .pop_i      (pop)
);

/* bench/tb_mram_test.sv */
`timescale 1ns/1ps

module tb_mram_test
    import mram_test_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYC    = 16;
    localparam int T_READ     = CYCLE_TPRE_DEF + CYCLE_TREAD_DEF + CYCLE_TRONA_DEF;
    localparam int N_RECORDS  = 20;
    // reads done with a free running uart before the stall
    localparam int N_FIRST    = 8;
    localparam int STALL_CYC  = 100;
    localparam int MAX_TX_DLY = 8;
    // one read, the pop and two bytes at the longest uart delay
    localparam int WORST_CYC  = T_READ + 3 + 2 * (MAX_TX_DLY + 2);
    localparam int LIMIT_CYC  = 2 * (RST_CYC + STALL_CYC + N_RECORDS * WORST_CYC);

    logic         CLK_200 = 1'b0;
    logic         Rst_n;
    logic         rd_trigger_i;
    uart_byte_t   do_i;
    logic [1:0]   err_code_i;
    logic [3:0]   err_bit_addr_i;
    logic         tx_done_i;
    logic         en_o;
    logic         r_clk_o;
    logic         mux_en_o;
    logic         tx_start_o;
    uart_byte_t   tx_byte_o;

    // expected records in read order
    mram_record_t exp_q[$];
    int           reads_started = 0;
    int           reads_done = 0;
    int           rec_out = 0;
    int           err_cnt = 0;
    // low while the data byte of the head record is due
    logic         ecc_phase = 1'b0;
    logic         uart_busy = 1'b0;
    logic         uart_stall = 1'b0;
    logic [31:0]  rnd_state = 32'd92;

    mram_test_top #(
        .CYCLE_TPRE  (CYCLE_TPRE_DEF),
        .CYCLE_TREAD (CYCLE_TREAD_DEF),
        .CYCLE_TRONA (CYCLE_TRONA_DEF),
        .FIFO_DEPTH  (FIFO_DEPTH_DEF)
    ) u_mram_test_top (.*);

    always #(CLK_PERIOD / 2) CLK_200 = ~CLK_200;

    function automatic logic [31:0] lcg_next();
        rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
        return rnd_state;
    endfunction

    task automatic note_error(input string msg);
        $display("** Error @%0t: %s", $time, msg);
        err_cnt++;
    endtask

    // compare one uart byte with the head of the expected queue
    task automatic check_tx_byte(input uart_byte_t got);
        mram_record_t exp_rec;
        uart_byte_t   exp_byte;
        if (exp_q.size() == 0) begin
            $display("tx_start_o seen at %0t with no record queued", $time);
            err_cnt++;
            return;
        end
        exp_rec = exp_q[0];
        // ecc byte is error address, two zero bits, error code
        exp_byte = ecc_phase ? {exp_rec.err_bit_addr, 2'b00, exp_rec.err_code} : exp_rec.data;
        assert (got == exp_byte)
            else note_error($sformatf("byte %0d of record %0d is %02h, expected %02h",
                                      ecc_phase, rec_out, got, exp_byte));
        if (ecc_phase) begin
            void'(exp_q.pop_front());
            rec_out++;
        end
        ecc_phase = !ecc_phase;
    endtask

    // all started reads finished and every byte answered
    task automatic wait_drained();
        repeat (2) @(negedge CLK_200);
        while (reads_done != reads_started || exp_q.size() != 0 || uart_busy) begin
            @(negedge CLK_200);
        end
    endtask

    ////////////////////
    // macro and uart models

    // fresh macro outputs at the start of each read, held through it
    initial begin : macro_model
        logic        in_read;
        logic [31:0] r;
        in_read        = 1'b0;
        do_i           = '0;
        err_code_i     = '0;
        err_bit_addr_i = '0;
        forever begin
            @(negedge CLK_200);
            if (en_o && !in_read) begin
                r              = lcg_next();
                do_i           = r[31:24];
                err_code_i     = r[21:20];
                err_bit_addr_i = r[19:16];
                reads_started++;
            end else if (!en_o && in_read) begin
                exp_q.push_back('{err_bit_addr: err_bit_addr_i, err_code: err_code_i,
                                  data: do_i});
                reads_done++;
            end
            in_read = en_o;
        end
    end

    // answers each byte after 1 to 8 cycles, or not at all while stalled
    initial begin : uart_model
        int dly;
        tx_done_i = 1'b0;
        forever begin
            @(negedge CLK_200);
            tx_done_i = 1'b0;
            if (tx_start_o) begin
                uart_busy = 1'b1;
                check_tx_byte(tx_byte_o);
                dly = 1 + int'(lcg_next() >> 29);
                repeat (dly) @(negedge CLK_200);
                while (uart_stall) @(negedge CLK_200);
                tx_done_i = 1'b1;
                uart_busy = 1'b0;
            end
        end
    end

    ////////////////////
    // test sequence

    initial begin : stimulus
        logic [31:0] r;
        int          base;
        int          prop_fails;
        Rst_n        = 1'b0;
        rd_trigger_i = 1'b0;
        repeat (RST_CYC) @(negedge CLK_200);
        Rst_n = 1'b1;
        repeat (3) @(negedge CLK_200);
        assert (mux_en_o && !en_o && !r_clk_o && !tx_start_o)
            else note_error("output levels after reset are wrong");

        // random trigger against a free uart
        while (reads_started < N_FIRST) begin
            r            = lcg_next();
            rd_trigger_i = r[31];
            @(negedge CLK_200);
        end
        rd_trigger_i = 1'b0;
        wait_drained();

        // stalled uart, trigger held, fifo plus the packer's record fill up
        uart_stall   = 1'b1;
        base         = reads_started;
        rd_trigger_i = 1'b1;
        repeat (STALL_CYC) @(negedge CLK_200);
        assert (reads_started - base == FIFO_DEPTH_DEF + 1 && !en_o)
            else note_error($sformatf("%0d reads under stall, expected %0d",
                                      reads_started - base, FIFO_DEPTH_DEF + 1));

        // release, drain and keep reading up to the full count
        uart_stall = 1'b0;
        while (reads_started < N_RECORDS) @(negedge CLK_200);
        rd_trigger_i = 1'b0;
        wait_drained();
        repeat (5) @(negedge CLK_200);
        assert (rec_out == N_RECORDS)
            else note_error($sformatf("%0d records sent, expected %0d", rec_out, N_RECORDS));

        prop_fails = u_mram_test_top.u_props.prop_fail_cnt;
        $display("scoreboard errors: %0d, assertion failures: %0d", err_cnt, prop_fails);
        if (err_cnt == 0 && prop_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        #(LIMIT_CYC * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", LIMIT_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tb_mram_test -f sources.f \
    && ./obj_dir/Vtb_mram_test +verilator+error+limit+100)
echo "$out"
grep -qF "PASS: all tests" <<< "$out" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sources.f */
src/mram_test_pkg.sv
src/mram_read_seq.sv
src/record_fifo.sv
src/uart_record_packer.sv
src/mram_test_top.sv
bench/mram_test_properties.sv
bench/tb_mram_test.sv

/* src/mram_read_seq.sv */
`timescale 1ns/1ps

module mram_read_seq
    import mram_test_pkg::*;
#(
    parameter int CYCLE_TPRE  = CYCLE_TPRE_DEF,
    parameter int CYCLE_TREAD = CYCLE_TREAD_DEF,
    parameter int CYCLE_TRONA = CYCLE_TRONA_DEF,
    parameter int FIFO_DEPTH  = FIFO_DEPTH_DEF
) (
    input  logic         CLK_200,
    input  logic         Rst_n,
    // read request, honoured only in idle with a credit
    input  logic         rd_trigger_i,
    // macro outputs
    input  uart_byte_t   do_i,
    input  logic [1:0]   err_code_i,
    input  logic [3:0]   err_bit_addr_i,
    // one pulse per record leaving the fifo
    input  logic         credit_return_i,
    // macro pins
    output logic         en_o,
    output logic         r_clk_o,
    output logic         mux_en_o,
    // record handoff to the fifo
    output logic         capture_valid_o,
    output mram_record_t capture_rec_o
);

    // enough bits to hold a full set of credits
    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    read_phase_e        phase_q;
    read_phase_e        phase_nxt;
    cycle_cnt_t         cnt_q;
    cycle_cnt_t         cnt_last;
    logic               phase_done;
    logic               rd_start;
    logic               cap_now;
    logic [CRED_W-1:0]  credit_q;
    logic               has_credit;

    ////////////////////
    // phase control

    // last count value of the current phase
    always_comb begin
        case (phase_q)
            PH_TPRE:  cnt_last = cycle_cnt_t'(CYCLE_TPRE - 1);
            PH_TREAD: cnt_last = cycle_cnt_t'(CYCLE_TREAD - 1);
            PH_TRONA: cnt_last = cycle_cnt_t'(CYCLE_TRONA - 1);
            default:  cnt_last = '0;
        endcase
    end

    assign phase_done = (phase_q != PH_IDLE) && (cnt_q == cnt_last);
    assign has_credit = (credit_q != '0);
    // start only when the fifo is sure to have room
    assign rd_start   = (phase_q == PH_IDLE) && rd_trigger_i && has_credit;
    // last hold cycle
    assign cap_now    = (phase_q == PH_TRONA) && phase_done;

    always_comb begin
        phase_nxt = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (rd_start) phase_nxt = PH_TPRE;
            end
            PH_TPRE: begin
                if (phase_done) phase_nxt = PH_TREAD;
            end
            PH_TREAD: begin
                if (phase_done) phase_nxt = PH_TRONA;
            end
            PH_TRONA: begin
                if (phase_done) phase_nxt = PH_IDLE;
            end
            default: begin
                phase_nxt = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            phase_q <= PH_IDLE;
            cnt_q   <= '0;
        end else begin
            phase_q <= phase_nxt;
            // counter restarts at every phase boundary
            if (phase_q == PH_IDLE || phase_done) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    ////////////////////
    // macro pins

    // decoded straight from the phase register
    assign en_o     = (phase_q != PH_IDLE);
    assign r_clk_o  = (phase_q == PH_TREAD);
    // idle indicator
    assign mux_en_o = (phase_q == PH_IDLE);

    ////////////////////
    // capture

    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            capture_valid_o <= 1'b0;
        end else begin
            capture_valid_o <= cap_now;
        end
    end

    // sample the macro outputs as they stand in the last hold cycle
    always_ff @(posedge CLK_200) begin
        if (cap_now) begin
            capture_rec_o.err_bit_addr <= err_bit_addr_i;
            capture_rec_o.err_code     <= err_code_i;
            capture_rec_o.data         <= do_i;
        end
    end

    ////////////////////
    // credits

    // spent at capture so the count is current by the next idle cycle
    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            credit_q <= CRED_W'(FIFO_DEPTH);
        end else begin
            case ({cap_now, credit_return_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                // spend and return together cancel
                default: credit_q <= credit_q;
            endcase
        end
    end

endmodule

/* src/mram_test_pkg.sv */
package mram_test_pkg;

    ////////////////////
    // phase timing

    // one counter type shared by all read phases
    typedef logic [5:0] cycle_cnt_t;

    // precharge length in CLK_200 cycles
    localparam int CYCLE_TPRE_DEF  = 2;

    // read strobe length, r_clk high for this many cycles
    localparam int CYCLE_TREAD_DEF = 4;

    // read-out hold length
    // keep above 2 so the macro outputs settle before capture
    localparam int CYCLE_TRONA_DEF = 3;

    ////////////////////
    // record store

    // records held between sequencer and packer
    // also the number of read credits after reset
    localparam int FIFO_DEPTH_DEF  = 4;

    ////////////////////
    // encodings and payloads

    // read sequencer phases
    typedef enum logic [1:0] {
        PH_IDLE  = 2'd0,
        PH_TPRE  = 2'd1,
        PH_TREAD = 2'd2,
        PH_TRONA = 2'd3
    } read_phase_e;

    // one sampled read of the macro
    // msb first, matches the raw {err_bit_addr, err_code, do} word
    typedef struct packed {
        // bit position flagged by the ecc decoder
        logic [3:0] err_bit_addr;
        // ecc status code from the macro
        logic [1:0] err_code;
        // corrected read data
        logic [7:0] data;
    } mram_record_t;

    // one byte handed to the uart transmitter
    typedef logic [7:0] uart_byte_t;

endpackage

/* src/mram_test_top.sv */
`timescale 1ns/1ps

module mram_test_top
    import mram_test_pkg::*;
#(
    parameter int CYCLE_TPRE  = CYCLE_TPRE_DEF,
    parameter int CYCLE_TREAD = CYCLE_TREAD_DEF,
    parameter int CYCLE_TRONA = CYCLE_TRONA_DEF,
    parameter int FIFO_DEPTH  = FIFO_DEPTH_DEF
) (
    input  logic         CLK_200,
    input  logic         Rst_n,
    input  logic         rd_trigger_i,
    // macro outputs
    input  uart_byte_t   do_i,
    input  logic [1:0]   err_code_i,
    input  logic [3:0]   err_bit_addr_i,
    // uart side
    input  logic         tx_done_i,
    // macro pins
    output logic         en_o,
    output logic         r_clk_o,
    output logic         mux_en_o,
    output logic         tx_start_o,
    output uart_byte_t   tx_byte_o
);

    // sequencer to fifo
    logic           capture_valid;
    mram_record_t   capture_rec;
    logic           credit_return;
    // fifo to packer
    mram_record_t   fifo_rec;
    logic           fifo_rec_valid;
    logic           pop;

    ////////////////////
    // read sequencer

    mram_read_seq #(
        .CYCLE_TPRE  (CYCLE_TPRE),
        .CYCLE_TREAD (CYCLE_TREAD),
        .CYCLE_TRONA (CYCLE_TRONA),
        // credit count must match the fifo depth
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_read_seq (
        .CLK_200         (CLK_200),
        .Rst_n           (Rst_n),
        .rd_trigger_i    (rd_trigger_i),
        .do_i            (do_i),
        .err_code_i      (err_code_i),
        .err_bit_addr_i  (err_bit_addr_i),
        .credit_return_i (credit_return),
        .en_o            (en_o),
        .r_clk_o         (r_clk_o),
        .mux_en_o        (mux_en_o),
        .capture_valid_o (capture_valid),
        .capture_rec_o   (capture_rec)
    );

    ////////////////////
    // record store

    record_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK_200         (CLK_200),
        .Rst_n           (Rst_n),
        .push_i          (capture_valid),
        .push_rec_i      (capture_rec),
        .pop_i           (pop),
        .rec_o           (fifo_rec),
        .rec_valid_o     (fifo_rec_valid),
        .credit_return_o (credit_return)
    );

    ////////////////////
    // uart packer

    uart_record_packer u_packer (
        .CLK_200     (CLK_200),
        .Rst_n       (Rst_n),
        .rec_i       (fifo_rec),
        .rec_valid_i (fifo_rec_valid),
        .tx_done_i   (tx_done_i),
        .pop_o       (pop),
        .tx_start_o  (tx_start_o),
        .tx_byte_o   (tx_byte_o)
    );

endmodule

/* src/record_fifo.sv */
`timescale 1ns/1ps

module record_fifo
    import mram_test_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH_DEF
) (
    input  logic         CLK_200,
    input  logic         Rst_n,
    // write side, room is guaranteed by the sequencer credits
    input  logic         push_i,
    input  mram_record_t push_rec_i,
    // read side
    input  logic         pop_i,
    output mram_record_t rec_o,
    output logic         rec_valid_o,
    // one pulse per record removed
    output logic         credit_return_o
);

    // pointer and count widths
    // a depth of 1 still needs a one bit pointer
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mram_record_t       mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               pop_ok;

    // circular advance, works for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        logic [PTR_W-1:0] nxt;
        if (p == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = p + 1'b1;
        end
        return nxt;
    endfunction

    ////////////////////
    // status

    assign rec_valid_o     = (count != '0);
    // ignore a pop on an empty store
    assign pop_ok          = pop_i && rec_valid_o;
    // credit goes back in the same cycle as the pop
    assign credit_return_o = pop_ok;

    // head record, valid while rec_valid_o is high
    assign rec_o = mem[rd_ptr];

    ////////////////////
    // storage

    always_ff @(posedge CLK_200) begin
        if (push_i) begin
            mem[wr_ptr] <= push_rec_i;
        end
    end

    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // occupancy
            case ({push_i, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/uart_record_packer.sv */
`timescale 1ns/1ps

module uart_record_packer
    import mram_test_pkg::*;
(
    input  logic         CLK_200,
    input  logic         Rst_n,
    // head of the record fifo
    input  mram_record_t rec_i,
    input  logic         rec_valid_i,
    // uart handshake
    input  logic         tx_done_i,
    output logic         pop_o,
    output logic         tx_start_o,
    output uart_byte_t   tx_byte_o
);

    // packer states
    typedef enum logic [1:0] {
        PK_IDLE = 2'd0,
        PK_POP  = 2'd1,
        PK_SEND = 2'd2
    } pk_state_e;

    pk_state_e      state_q;
    mram_record_t   hold_rec;
    // low for the data byte, high for the ecc byte
    logic           ecc_sel;
    logic           byte_done;

    // a done in the same cycle as our start belongs to nothing
    assign byte_done = tx_done_i && !tx_start_o;

    ////////////////////
    // byte select

    // ecc byte is {err_bit_addr, 2'b00, err_code}
    assign tx_byte_o = ecc_sel ? {hold_rec.err_bit_addr, 2'b00, hold_rec.err_code}
                               : hold_rec.data;

    ////////////////////
    // control

    always_ff @(posedge CLK_200 or negedge Rst_n) begin
        if (!Rst_n) begin
            state_q    <= PK_IDLE;
            pop_o      <= 1'b0;
            tx_start_o <= 1'b0;
            ecc_sel    <= 1'b0;
        end else begin
            // strobes last one cycle
            pop_o      <= 1'b0;
            tx_start_o <= 1'b0;
            case (state_q)
                PK_IDLE: begin
                    // nothing in flight, take the head record
                    if (rec_valid_i) begin
                        pop_o   <= 1'b1;
                        state_q <= PK_POP;
                    end
                end
                PK_POP: begin
                    // head is latched this cycle, data byte goes next
                    ecc_sel    <= 1'b0;
                    tx_start_o <= 1'b1;
                    state_q    <= PK_SEND;
                end
                PK_SEND: begin
                    if (byte_done) begin
                        if (!ecc_sel) begin
                            // data byte out, now the ecc byte
                            ecc_sel    <= 1'b1;
                            tx_start_o <= 1'b1;
                        end else begin
                            // both bytes out
                            ecc_sel <= 1'b0;
                            state_q <= PK_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= PK_IDLE;
                end
            endcase
        end
    end

    // record copy for the two byte sends
    always_ff @(posedge CLK_200) begin
        if (state_q == PK_POP) begin
            hold_rec <= rec_i;
        end
    end

endmodule
